// File: design/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // 640x480 mode, counted in pixel positions per line and lines per frame
  localparam int h_visible     = 640;
  localparam int h_front_porch = 16;
  localparam int h_sync_pulse  = 96;
  localparam int h_back_porch  = 48;
  localparam int h_whole_line  = h_visible + h_front_porch + h_sync_pulse + h_back_porch;

  localparam int v_visible     = 480;
  localparam int v_front_porch = 10;
  localparam int v_sync_pulse  = 2;
  localparam int v_back_porch  = 33;
  localparam int v_whole_frame = v_visible + v_front_porch + v_sync_pulse + v_back_porch;

  // sync pulse windows, half open [start, end)
  localparam int h_sync_start = h_visible + h_front_porch;
  localparam int h_sync_end   = h_sync_start + h_sync_pulse;
  localparam int v_sync_start = v_visible + v_front_porch;
  localparam int v_sync_end   = v_sync_start + v_sync_pulse;

  // both sync outputs are active low
  localparam logic sync_active = 1'b0;

  localparam int fb_addr_bits           = 20;
  localparam int fb_data_bits           = 16;
  localparam int color_bits             = 4;
  localparam int ctx_fifo_depth_log2    = 3;
  localparam int ctx_fifo_depth         = 1 << ctx_fifo_depth_log2;
  localparam int ctx_almost_full_margin = 2;

  typedef logic [$clog2(h_whole_line)-1:0]  column_t;
  typedef logic [$clog2(v_whole_frame)-1:0] row_t;

  // word address, row * h_visible + column
  typedef logic [fb_addr_bits-1:0] fb_addr_t;
  // bits 11:8 red, 7:4 green, 3:0 blue
  typedef logic [fb_data_bits-1:0] fb_data_t;
  typedef logic [color_bits-1:0]   color_t;

  typedef logic [ctx_fifo_depth_log2-1:0] ctx_ptr_t;
  typedef logic [ctx_fifo_depth_log2:0]   ctx_count_t;

  typedef struct packed {
    logic visible;
    logic vsync;
    logic hsync;
  } pixel_ctx_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } rgb_t;

  typedef enum logic {
    read_idle,
    read_issuing
  } read_state_t;

endpackage

`default_nettype wire

// File: design/vga_raster_timing.sv
`default_nettype none
`timescale 1ns/10ps

module vga_raster_timing (
  input  logic                clk,
  input  logic                reset,
  input  logic                step,
  output vga_pkg::column_t    column,
  output vga_pkg::row_t       row,
  output vga_pkg::pixel_ctx_t ctx
);

  logic last_column;
  logic last_row;
  logic in_hsync;
  logic in_vsync;

  assign last_column = (column == vga_pkg::column_t'(vga_pkg::h_whole_line - 1));
  assign last_row    = (row == vga_pkg::row_t'(vga_pkg::v_whole_frame - 1));

  // counters only move on a step, the position is held otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
      row    <= '0;
    end else if (step) begin
      if (last_column) begin
        column <= '0;
        if (last_row) begin
          row <= '0;
        end else begin
          row <= row + vga_pkg::row_t'(1);
        end
      end else begin
        column <= column + vga_pkg::column_t'(1);
      end
    end
  end

  assign in_hsync = (column >= vga_pkg::column_t'(vga_pkg::h_sync_start)) &&
                    (column <  vga_pkg::column_t'(vga_pkg::h_sync_end));
  assign in_vsync = (row >= vga_pkg::row_t'(vga_pkg::v_sync_start)) &&
                    (row <  vga_pkg::row_t'(vga_pkg::v_sync_end));

  // context of the position currently held by the counters
  always_comb begin
    ctx.visible = (column < vga_pkg::column_t'(vga_pkg::h_visible)) &&
                  (row < vga_pkg::row_t'(vga_pkg::v_visible));
    ctx.hsync   = in_hsync ? vga_pkg::sync_active : !vga_pkg::sync_active;
    ctx.vsync   = in_vsync ? vga_pkg::sync_active : !vga_pkg::sync_active;
  end

  // the wrap logic must keep the raster inside the frame
  a_position_in_frame: assert property (
    @(posedge clk) disable iff (reset)
    (column < vga_pkg::column_t'(vga_pkg::h_whole_line)) &&
    (row < vga_pkg::row_t'(vga_pkg::v_whole_frame))
  ) else $error("raster position outside the frame");

endmodule

`default_nettype wire

// File: design/fb_read_master.sv
`default_nettype none
`timescale 1ns/10ps

module fb_read_master (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic                fifo_almost_full,
  input  vga_pkg::column_t    column,
  input  vga_pkg::row_t       row,
  input  vga_pkg::pixel_ctx_t ctx,
  input  logic                arready,
  output logic                read_start,
  output vga_pkg::pixel_ctx_t ctx_p1,
  output vga_pkg::fb_addr_t   araddr,
  output logic                arvalid
);

  vga_pkg::fb_addr_t    addr_calc;
  vga_pkg::fb_addr_t    addr_p1;
  logic                 enable_p1;
  logic                 start_p1;
  logic                 fetch_ok;
  logic                 read_accepted;
  vga_pkg::read_state_t state;
  vga_pkg::read_state_t next_state;

  assign addr_calc = vga_pkg::fb_addr_t'(row) * vga_pkg::fb_addr_t'(vga_pkg::h_visible) +
                     vga_pkg::fb_addr_t'(column);

  // address pipeline stage, a copy of the raster one cycle behind
  always_ff @(posedge clk) begin
    addr_p1 <= addr_calc;
    ctx_p1  <= ctx;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_p1 <= 1'b0;
      start_p1  <= 1'b0;
    end else begin
      enable_p1 <= enable && !fifo_almost_full;
      start_p1  <= read_start;
    end
  end

  assign read_accepted = arvalid && arready;

  // a read moves the counters, so the copy is stale on the next cycle
  assign fetch_ok = enable_p1 && ctx_p1.visible && !start_p1 && !fifo_almost_full;

  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      vga_pkg::read_idle: begin
        // blanking positions never leave idle
        if (fetch_ok) begin
          read_start = 1'b1;
          next_state = vga_pkg::read_issuing;
        end
      end
      vga_pkg::read_issuing: begin
        if (read_accepted) begin
          if (fetch_ok) begin
            read_start = 1'b1;
          end else begin
            next_state = vga_pkg::read_idle;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= vga_pkg::read_idle;
      arvalid <= 1'b0;
    end else begin
      state <= next_state;
      if (read_start) begin
        arvalid <= 1'b1;
      end else if (read_accepted) begin
        arvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) begin
      araddr <= addr_p1;
    end
  end

  a_araddr_stable: assert property (
    @(posedge clk) disable iff (reset)
    arvalid && !arready |=> $stable(araddr)
  ) else $error("araddr changed while the request was pending");

  a_arvalid_held: assert property (
    @(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid
  ) else $error("arvalid dropped without an acceptance");

endmodule

`default_nettype wire

// File: design/pixel_context_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_context_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  vga_pkg::pixel_ctx_t push_data,
  input  logic                pop,
  output vga_pkg::pixel_ctx_t head,
  output logic                empty,
  output logic                full,
  output logic                almost_full
);

  vga_pkg::pixel_ctx_t mem [vga_pkg::ctx_fifo_depth];
  vga_pkg::ctx_ptr_t   wr_ptr;
  vga_pkg::ctx_ptr_t   rd_ptr;
  vga_pkg::ctx_count_t count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + vga_pkg::ctx_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + vga_pkg::ctx_ptr_t'(1);
      end
      if (push && !pop) begin
        count <= count + vga_pkg::ctx_count_t'(1);
      end else if (pop && !push) begin
        count <= count - vga_pkg::ctx_count_t'(1);
      end
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == vga_pkg::ctx_count_t'(vga_pkg::ctx_fifo_depth));
  // margin covers the step already in the address pipeline
  assign almost_full = (count >= vga_pkg::ctx_count_t'(vga_pkg::ctx_fifo_depth -
                                                       vga_pkg::ctx_almost_full_margin));

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) push |-> !full
  ) else $error("context fifo push while full");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset) pop |-> !empty
  ) else $error("context fifo pop while empty");

endmodule

`default_nettype wire

// File: design/pixel_merge.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_merge (
  input  logic                clk,
  input  logic                reset,
  input  vga_pkg::pixel_ctx_t head,
  input  logic                empty,
  input  vga_pkg::fb_data_t   rdata,
  input  logic                rvalid,
  output logic                pop,
  output logic                valid,
  output logic                hsync,
  output logic                vsync,
  output vga_pkg::rgb_t       color
);

  logic          pix_visible;
  vga_pkg::rgb_t pix_rgb;

  // blanking entries leave at once, visible ones wait for their data
  assign pop = !empty && (!head.visible || rvalid);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      pix_visible <= head.visible;
      hsync       <= head.hsync;
      vsync       <= head.vsync;
    end
    if (rvalid) begin
      pix_rgb <= vga_pkg::rgb_t'(rdata[3*vga_pkg::color_bits-1:0]);
    end
  end

  assign color = pix_visible ? pix_rgb : '0;

  // read data must never get ahead of its context entry
  a_rvalid_has_context: assert property (
    @(posedge clk) disable iff (reset)
    rvalid |-> !empty && head.visible
  ) else $error("read data arrived without a visible context at the head");

endmodule

`default_nettype wire

// File: design/vga_fb_pixel_stream.sv
`default_nettype none
`timescale 1ns/10ps

module vga_fb_pixel_stream (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  logic              arready,
  input  vga_pkg::fb_data_t rdata,
  input  logic              rvalid,
  output logic              valid,
  output logic              hsync,
  output logic              vsync,
  output vga_pkg::rgb_t     color,
  output vga_pkg::fb_addr_t araddr,
  output logic              arvalid,
  output logic              rready
);

  vga_pkg::column_t    column;
  vga_pkg::row_t       row;
  vga_pkg::pixel_ctx_t ctx;
  vga_pkg::pixel_ctx_t ctx_p1;
  vga_pkg::pixel_ctx_t fifo_head;
  logic                read_start;
  logic                step;
  logic                step_p1;
  logic                fifo_empty;
  logic                fifo_almost_full;
  logic                fifo_pop;

  // visible positions advance through a read, blanking ones on enable alone
  assign step = !fifo_almost_full && (read_start || (!ctx.visible && enable));

  always_ff @(posedge clk) begin
    if (reset) begin
      step_p1 <= 1'b0;
    end else begin
      step_p1 <= step;
    end
  end

  // read data is always accepted
  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b1;
    end
  end

  vga_raster_timing i_raster (
    .clk    (clk),
    .reset  (reset),
    .step   (step),
    .column (column),
    .row    (row),
    .ctx    (ctx)
  );

  fb_read_master i_read_master (
    .clk              (clk),
    .reset            (reset),
    .enable           (enable),
    .fifo_almost_full (fifo_almost_full),
    .column           (column),
    .row              (row),
    .ctx              (ctx),
    .arready          (arready),
    .read_start       (read_start),
    .ctx_p1           (ctx_p1),
    .araddr           (araddr),
    .arvalid          (arvalid)
  );

  pixel_context_fifo i_ctx_fifo (
    .clk         (clk),
    .reset       (reset),
    .push        (step_p1),
    .push_data   (ctx_p1),
    .pop         (fifo_pop),
    .head        (fifo_head),
    .empty       (fifo_empty),
    .full        (),
    .almost_full (fifo_almost_full)
  );

  pixel_merge i_merge (
    .clk    (clk),
    .reset  (reset),
    .head   (fifo_head),
    .empty  (fifo_empty),
    .rdata  (rdata),
    .rvalid (rvalid),
    .pop    (fifo_pop),
    .valid  (valid),
    .hsync  (hsync),
    .vsync  (vsync),
    .color  (color)
  );

endmodule

`default_nettype wire

// File: testbench/fb_sram_model.sv
`default_nettype none
`timescale 1ns/10ps

module fb_sram_model (
  input  logic              clk,
  input  logic              reset,
  input  vga_pkg::fb_addr_t araddr,
  input  logic              arvalid,
  input  logic              arready,
  output vga_pkg::fb_data_t rdata,
  output logic              rvalid,
  output logic              hold_error
);

  // each word is its own address folded with a fixed mask
  localparam vga_pkg::fb_data_t data_mask = 16'h5A3C;

  logic              pending;
  vga_pkg::fb_addr_t pending_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid     <= 1'b0;
      rdata      <= '0;
      pending    <= 1'b0;
      hold_error <= 1'b0;
    end else begin
      // one cycle read latency after acceptance
      rvalid <= arvalid && arready;
      if (arvalid && arready) begin
        rdata <= vga_pkg::fb_data_t'(araddr[15:0]) ^ data_mask;
      end
      // a request left waiting must still be there, unchanged
      if (pending && (!arvalid || araddr != pending_addr)) begin
        hold_error <= 1'b1;
      end
      pending      <= arvalid && !arready;
      pending_addr <= araddr;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_vga_fb_pixel_stream.sv
`default_nettype none
`timescale 1ns/10ps

module tb_vga_fb_pixel_stream;

  typedef struct packed {
    vga_pkg::pixel_ctx_t sync;
    vga_pkg::rgb_t       rgb;
  } pixel_expect_t;

  localparam int reset_cycles       = 10;
  localparam int quiet_cycles       = 10;
  localparam int valid_timeout      = 2000;
  localparam int total_pixels       = vga_pkg::h_whole_line * vga_pkg::v_whole_frame + 1600;
  localparam int steady_start       = 10 * vga_pkg::h_whole_line;
  localparam int steady_cycles      = 1600;
  localparam int steady_min_strobes = 320;
  localparam logic [15:0] sram_mask = 16'h5A3C;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic              enable = 1'b0;
  logic              arready = 1'b0;
  vga_pkg::fb_data_t rdata;
  logic              rvalid;
  logic              valid;
  logic              hsync;
  logic              vsync;
  vga_pkg::rgb_t     color;
  vga_pkg::fb_addr_t araddr;
  logic              arvalid;
  logic              rready;
  logic              hold_error;

  integer      seed = 32'h6659;
  logic [31:0] draw;
  logic        stim_on = 1'b0;
  logic        window_active = 1'b0;
  logic        window_done = 1'b0;
  int          strobes = 0;
  int          window_cycles = 0;
  int          window_strobes = 0;

  always #20 clk = ~clk;

  vga_fb_pixel_stream i_dut (
    .clk     (clk),
    .reset   (reset),
    .enable  (enable),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .valid   (valid),
    .hsync   (hsync),
    .vsync   (vsync),
    .color   (color),
    .araddr  (araddr),
    .arvalid (arvalid),
    .rready  (rready)
  );

  fb_sram_model i_sram (
    .clk        (clk),
    .reset      (reset),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .hold_error (hold_error)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // expected pixel n of the raster, counted from column 0 row 0
  function automatic pixel_expect_t expected_pixel(input int n);
    int            col;
    int            row;
    logic [15:0]   word;
    pixel_expect_t e;
    col = n % vga_pkg::h_whole_line;
    row = (n / vga_pkg::h_whole_line) % vga_pkg::v_whole_frame;
    e.sync.visible = (col < vga_pkg::h_visible) && (row < vga_pkg::v_visible);
    // active low pulses right after the front porch
    e.sync.hsync = !((col >= vga_pkg::h_visible + vga_pkg::h_front_porch) &&
                     (col < vga_pkg::h_visible + vga_pkg::h_front_porch +
                            vga_pkg::h_sync_pulse));
    e.sync.vsync = !((row >= vga_pkg::v_visible + vga_pkg::v_front_porch) &&
                     (row < vga_pkg::v_visible + vga_pkg::v_front_porch +
                            vga_pkg::v_sync_pulse));
    word = 16'(row * vga_pkg::h_visible + col) ^ sram_mask;
    e.rgb = e.sync.visible ? vga_pkg::rgb_t'(word[11:0]) : '0;
    return e;
  endfunction

  task automatic check_sync(input int index, input vga_pkg::pixel_ctx_t got,
                            input vga_pkg::pixel_ctx_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch pixel_ctx at pixel %0d: got %h expected %h",
                                  index, got, exp));
    end
  endtask

  task automatic check_color(input int index, input vga_pkg::rgb_t got,
                             input vga_pkg::rgb_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch color at pixel %0d: got %h expected %h",
                                  index, got, exp));
    end
  endtask

  task automatic compare_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic wait_for_valid(input int index);
    int waited;
    waited = 0;
    @(negedge clk);
    while (valid !== 1'b1) begin
      if (waited >= valid_timeout) begin
        stop_with_failure($sformatf("no valid strobe for pixel %0d within %0d cycles",
                                    index, valid_timeout));
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  // random enable and arready outside the line 10 stretch
  always @(negedge clk) begin
    if (!stim_on) begin
      enable  = 1'b0;
      arready = 1'b0;
    end else if (window_active) begin
      enable  = 1'b1;
      arready = 1'b1;
    end else begin
      draw    = $random(seed);
      enable  = (draw[1:0] != 2'b00);
      arready = draw[4];
    end
  end

  // strobe count and the line 10 throughput window
  always @(negedge clk) begin
    if (!reset) begin
      if (window_active) begin
        window_cycles++;
        if (valid === 1'b1) begin
          window_strobes++;
        end
        if (window_cycles == steady_cycles) begin
          window_active <= 1'b0;
          window_done   <= 1'b1;
          if (window_strobes < steady_min_strobes) begin
            stop_with_failure($sformatf("only %0d pixels in %0d cycles with the path held open",
                                        window_strobes, steady_cycles));
          end
        end
      end else if (!window_done && strobes == steady_start) begin
        window_active  <= 1'b1;
        window_cycles  = 0;
        window_strobes = 0;
      end
      if (valid === 1'b1) begin
        strobes++;
      end
    end
  end

  always @(negedge clk) begin
    if (hold_error === 1'b1) begin
      stop_with_failure("read request changed or was withdrawn before the SRAM accepted it");
    end
  end

  initial begin : main_sequence
    vga_pkg::pixel_ctx_t seen;
    pixel_expect_t       want;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    // nothing may move while enable is still low
    for (int i = 0; i < quiet_cycles; i++) begin
      @(negedge clk);
      compare_level("valid", valid, 1'b0);
      compare_level("arvalid", arvalid, 1'b0);
      compare_level("rready", rready, 1'b1);
    end
    stim_on <= 1'b1;
    for (int n = 0; n < total_pixels; n++) begin
      wait_for_valid(n);
      want         = expected_pixel(n);
      seen.visible = i_dut.i_merge.pix_visible;
      seen.vsync   = vsync;
      seen.hsync   = hsync;
      check_sync(n, seen, want.sync);
      check_color(n, color, want.rgb);
    end
    if (window_done) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure("the stretch with enable and arready held high never completed");
    end
  end

endmodule

`default_nettype wire

// File: flist.f
design/vga_pkg.sv
design/vga_raster_timing.sv
design/fb_read_master.sv
design/pixel_context_fifo.sv
design/pixel_merge.sv
design/vga_fb_pixel_stream.sv
testbench/fb_sram_model.sv
testbench/tb_vga_fb_pixel_stream.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vga_fb_pixel_stream
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FLIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
